/* files.f */
hw/mipsPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/mipsProcessor.sv
tb/mipsChecker.sv
tb/mipsProcessor_props.sv
tb/mipsProcessorTb.sv

/* hw/decodeStage.sv */
/* Register file is write-first and resets to zero; register 0 always reads zero
   Unknown opcodes and functs decode as a bubble with no side effects */
`timescale 1ns/1ps

module decodeStage (
	input  logic             clk,
	input  logic             arstN,
	input  logic             run,
	input  logic             branchTaken,
	input  logic             idValid,
	input  mipsPkg::word     idInstr,
	input  mipsPkg::imemAddr idPc,
	input  logic             wbEn,
	input  mipsPkg::regIdx   wbReg,
	input  mipsPkg::word     wbData,
	output logic             stall,
	output logic             exValid,
	output mipsPkg::aluOp    exAluOp,
	output logic             exUseImm,
	output logic             exMemRead,
	output logic             exMemWrite,
	output logic             exBranchEq,
	output logic             exBranchNe,
	output logic             exRegWrite,
	output mipsPkg::regIdx   exRs,
	output mipsPkg::regIdx   exRt,
	output mipsPkg::regIdx   exDest,
	output mipsPkg::word     exRsVal,
	output mipsPkg::word     exRtVal,
	output mipsPkg::word     exImm,
	output mipsPkg::imemAddr exPc
);
	import mipsPkg::*;

	word regs [32];
	opcode op;
	funct fn;
	regIdx rs, rt, rd, dest;
	word rsVal, rtVal, imm;
	aluOp aluSel;
	logic useImm, memRead, memWrite, branchEq, branchNe, regWrite;
	logic zeroExt, readsRs, readsRt, issue;

	// Instruction fields
	assign op = opcode'(idInstr[31:26]);
	assign fn = funct'(idInstr[5:0]);
	assign rs = idInstr[25:21];
	assign rt = idInstr[20:16];
	assign rd = idInstr[15:11];

	// Control decode
	always_comb begin
		aluSel = aluAdd;
		useImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchEq = 1'b0;
		branchNe = 1'b0;
		regWrite = 1'b0;
		zeroExt = 1'b0;
		readsRs = 1'b0;
		readsRt = 1'b0;
		dest = rt;
		case (op)
			opRType: begin
				dest = rd;
				readsRs = 1'b1;
				readsRt = 1'b1;
				regWrite = 1'b1;
				case (fn)
					fnAdd: aluSel = aluAdd;
					fnSub: aluSel = aluSub;
					fnAnd: aluSel = aluAnd;
					fnOr: aluSel = aluOr;
					fnNor: aluSel = aluNor;
					default: regWrite = 1'b0;
				endcase
			end
			opAddi, opLw: begin
				readsRs = 1'b1;
				useImm = 1'b1;
				regWrite = 1'b1;
				memRead = (op == opLw);
			end
			opOri: begin
				// Logical immediate, zero extended
				readsRs = 1'b1;
				useImm = 1'b1;
				regWrite = 1'b1;
				zeroExt = 1'b1;
				aluSel = aluOr;
			end
			opSw: begin
				readsRs = 1'b1;
				readsRt = 1'b1;
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			opBeq, opBne: begin
				readsRs = 1'b1;
				readsRt = 1'b1;
				branchEq = (op == opBeq);
				branchNe = (op == opBne);
			end
			default: ;
		endcase
	end

	assign imm = zeroExt ? {16'h0000, idInstr[15:0]} : {{16{idInstr[15]}}, idInstr[15:0]};

	// Register file write from WB
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn && wbReg != '0) begin
			regs[wbReg] <= wbData;
		end
	end

	// Reads see a same-cycle WB write
	assign rsVal = (rs == '0) ? '0 : (wbEn && wbReg == rs) ? wbData : regs[rs];
	assign rtVal = (rt == '0) ? '0 : (wbEn && wbReg == rt) ? wbData : regs[rt];

	// Load in EX feeding this instruction
	assign stall = idValid && exValid && exMemRead && exDest != '0 &&
		((readsRs && exDest == rs) || (readsRt && exDest == rt));

	// Bubble on stall, flush on taken branch
	assign issue = run && idValid && !stall && !branchTaken;

	// ID/EX control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exBranchEq <= 1'b0;
			exBranchNe <= 1'b0;
			exRegWrite <= 1'b0;
		end else begin
			exValid <= issue;
			exMemRead <= issue && memRead;
			exMemWrite <= issue && memWrite;
			exBranchEq <= issue && branchEq;
			exBranchNe <= issue && branchNe;
			exRegWrite <= issue && regWrite;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		exAluOp <= aluSel;
		exUseImm <= useImm;
		exRs <= rs;
		exRt <= rt;
		exDest <= dest;
		exRsVal <= rsVal;
		exRtVal <= rtVal;
		exImm <= imm;
		exPc <= idPc;
	end

endmodule

/* hw/executeStage.sv */
/* Forwarding covers ALU results in EX/MEM and any result in MEM/WB
   Load results are never taken from EX/MEM since decode stalls for those */
`timescale 1ns/1ps

module executeStage (
	input  logic             clk,
	input  logic             arstN,
	input  logic             run,
	input  logic             exValid,
	input  mipsPkg::aluOp    exAluOp,
	input  logic             exUseImm,
	input  logic             exMemRead,
	input  logic             exMemWrite,
	input  logic             exBranchEq,
	input  logic             exBranchNe,
	input  logic             exRegWrite,
	input  mipsPkg::regIdx   exRs,
	input  mipsPkg::regIdx   exRt,
	input  mipsPkg::regIdx   exDest,
	input  mipsPkg::word     exRsVal,
	input  mipsPkg::word     exRtVal,
	input  mipsPkg::word     exImm,
	input  mipsPkg::imemAddr exPc,
	input  logic             fwdEn,
	input  mipsPkg::regIdx   fwdReg,
	input  mipsPkg::word     fwdData,
	input  logic             wbEn,
	input  mipsPkg::regIdx   wbReg,
	input  mipsPkg::word     wbData,
	output logic             branchTaken,
	output mipsPkg::imemAddr branchTarget,
	output logic             memValid,
	output logic             memRegWrite,
	output logic             memRead,
	output logic             memWrite,
	output mipsPkg::regIdx   memDest,
	output mipsPkg::word     memResult,
	output mipsPkg::word     memStoreData
);
	import mipsPkg::*;

	word opA, opB, aluB, aluY;
	logic equal;

	// Youngest producer first and r0 never forwarded
	function automatic word pickOperand(regIdx r, word regVal);
		if (r != '0 && fwdEn && fwdReg == r) begin
			return fwdData;
		end else if (r != '0 && wbEn && wbReg == r) begin
			return wbData;
		end
		return regVal;
	endfunction

	// Operand select, also follows the forwarding ports
	always_comb begin
		opA = pickOperand(exRs, exRsVal);
		opB = pickOperand(exRt, exRtVal);
	end

	assign aluB = exUseImm ? exImm : opB;

	// ALU
	always_comb begin
		case (exAluOp)
			aluAdd: aluY = opA + aluB;
			aluSub: aluY = opA - aluB;
			aluAnd: aluY = opA & aluB;
			aluOr: aluY = opA | aluB;
			aluNor: aluY = ~(opA | aluB);
			default: aluY = opA + aluB;
		endcase
	end

	// Branch resolution on forwarded operands
	assign equal = (opA == opB);
	assign branchTaken = exValid && ((exBranchEq && equal) || (exBranchNe && !equal));
	// Offset in words relative to the next PC
	assign branchTarget = exPc + imemAddr'(1) + exImm[$bits(imemAddr)-1:0];

	// EX/MEM control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			memValid <= 1'b0;
			memRegWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			memValid <= run && exValid;
			memRegWrite <= run && exValid && exRegWrite;
			memRead <= run && exValid && exMemRead;
			memWrite <= run && exValid && exMemWrite;
		end
	end

	// EX/MEM payload with store data after forwarding
	always_ff @(posedge clk) begin
		memDest <= exDest;
		memResult <= aluY;
		memStoreData <= opB;
	end

endmodule

/* hw/fetchStage.sv */
/* Program words are accepted only while run is low; words never loaded read as X
   A taken branch wins over a stall, and a low run wins over both */
`timescale 1ns/1ps

module fetchStage (
	input  logic             clk,
	input  logic             arstN,
	input  logic             run,
	input  logic             progValid,
	output logic             progReady,
	input  mipsPkg::imemAddr progAddr,
	input  mipsPkg::word     progData,
	input  logic             stall,
	input  logic             branchTaken,
	input  mipsPkg::imemAddr branchTarget,
	output logic             idValid,
	output mipsPkg::word     idInstr,
	output mipsPkg::imemAddr idPc
);
	import mipsPkg::*;

	word imem [IMEM_DEPTH];
	imemAddr pc;

	// Load port open only with the core idle
	assign progReady = ~run;

	// Instruction memory write
	always_ff @(posedge clk) begin
		if (progValid && progReady) begin
			imem[progAddr] <= progData;
		end
	end

	// PC and IF/ID valid
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			idValid <= 1'b0;
		end else if (!run) begin
			// Idle, restart from word 0
			pc <= '0;
			idValid <= 1'b0;
		end else if (branchTaken) begin
			// Redirect, slot being fetched is dropped
			pc <= branchTarget;
			idValid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + imemAddr'(1);
			idValid <= 1'b1;
		end
	end

	// IF/ID payload, frozen on a load-use stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			idInstr <= imem[pc];
			idPc <= pc;
		end
	end

endmodule

/* hw/memoryStage.sv */
/* Data address bits 7:2 pick the word, bits 1:0 are ignored and higher bits wrap
   Words not yet stored since reset read as zero */
`timescale 1ns/1ps

module memoryStage (
	input  logic           clk,
	input  logic           arstN,
	input  logic           run,
	input  logic           memValid,
	input  logic           memRegWrite,
	input  logic           memRead,
	input  logic           memWrite,
	input  mipsPkg::regIdx memDest,
	input  mipsPkg::word   memResult,
	input  mipsPkg::word   memStoreData,
	output logic           fwdEn,
	output mipsPkg::regIdx fwdReg,
	output mipsPkg::word   fwdData,
	output logic           wbEn,
	output mipsPkg::regIdx wbReg,
	output mipsPkg::word   wbData,
	output logic           storeValid,
	output mipsPkg::word   storeAddr,
	output mipsPkg::word   storeData,
	output logic           retireValid,
	output mipsPkg::regIdx retireReg,
	output mipsPkg::word   retireData
);
	import mipsPkg::*;

	word dmem [DMEM_DEPTH];
	logic [DMEM_DEPTH-1:0] dmemWritten;
	dmemAddr idx;
	word loadData;

	assign idx = memResult[$bits(dmemAddr)+1:2];
	assign loadData = dmemWritten[idx] ? dmem[idx] : '0;

	// Store path
	always_ff @(posedge clk) begin
		if (memValid && memWrite) begin
			dmem[idx] <= memStoreData;
		end
	end

	// Written flags, zero-read for fresh words
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			dmemWritten <= '0;
		end else if (memValid && memWrite) begin
			dmemWritten[idx] <= 1'b1;
		end
	end

	// Store stream, one pulse per sw
	assign storeValid = memValid && memWrite;
	assign storeAddr = memResult;
	assign storeData = memStoreData;

	// ALU results only, a load is not ready here
	assign fwdEn = memValid && memRegWrite && !memRead;
	assign fwdReg = memDest;
	assign fwdData = memResult;

	// MEM/WB control
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbEn <= 1'b0;
		end else begin
			wbEn <= run && memValid && memRegWrite;
		end
	end

	// Writeback select ahead of MEM/WB
	always_ff @(posedge clk) begin
		wbReg <= memDest;
		wbData <= memRead ? loadData : memResult;
	end

	// Retire mirrors writeback, r0 writes hidden
	assign retireValid = wbEn && wbReg != '0;
	assign retireReg = wbReg;
	assign retireData = wbData;

endmodule

/* hw/mipsPkg.sv */
/* Memories hold 64 words each and the PC counts in words
   Opcode and funct codes follow the MIPS32 encoding */
package mipsPkg;

	// Memory sizes in words
	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;

	// Datapath word and register number
	typedef logic [31:0] word;
	typedef logic [4:0] regIdx;

	// Word indices into the two memories
	typedef logic [$clog2(IMEM_DEPTH)-1:0] imemAddr;
	typedef logic [$clog2(DMEM_DEPTH)-1:0] dmemAddr;

	// Primary opcode, instruction bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opAddi  = 6'h08,
		opOri   = 6'h0d,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcode;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnNor = 6'h27
	} funct;

	// Operation handed from decode to execute
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNor
	} aluOp;

endpackage

/* hw/mipsProcessor.sv */
/* Load the program with run low, then raise run; the program must end in a self-branch
   Retire and store streams have no back-pressure */
`timescale 1ns/1ps

module mipsProcessor (
	input  logic             clk,
	input  logic             arstN,
	input  logic             run,
	input  logic             progValid,
	output logic             progReady,
	input  mipsPkg::imemAddr progAddr,
	input  mipsPkg::word     progData,
	output logic             retireValid,
	output mipsPkg::regIdx   retireReg,
	output mipsPkg::word     retireData,
	output logic             storeValid,
	output mipsPkg::word     storeAddr,
	output mipsPkg::word     storeData
);
	import mipsPkg::*;

	// IF/ID and hazard feedback
	logic idValid, stall;
	word idInstr;
	imemAddr idPc;

	// Branch redirect from EX
	logic branchTaken;
	imemAddr branchTarget;

	// ID/EX
	logic exValid, exUseImm, exMemRead, exMemWrite;
	logic exBranchEq, exBranchNe, exRegWrite;
	aluOp exAluOp;
	regIdx exRs, exRt, exDest;
	word exRsVal, exRtVal, exImm;
	imemAddr exPc;

	// EX/MEM
	logic memValid, memRegWrite, memRead, memWrite;
	regIdx memDest;
	word memResult, memStoreData;

	// Forwarding and writeback ports
	logic fwdEn, wbEn;
	regIdx fwdReg, wbReg;
	word fwdData, wbData;

	// Stage ports share names with the wires above
	fetchStage fetchStage_inst (.*);

	decodeStage decodeStage_inst (.*);

	executeStage executeStage_inst (.*);

	memoryStage memoryStage_inst (.*);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mipsProcessorTb -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

/* tb/mipsChecker.sv */
/* Expected events are queued by the model before run rises
   Outputs are sampled on the rising edge, ahead of the DUT register updates */
`timescale 1ns/1ps

module mipsChecker (
	input logic           clk,
	input logic           arstN,
	input logic           run,
	input logic           progReady,
	input logic           retireValid,
	input mipsPkg::regIdx retireReg,
	input mipsPkg::word   retireData,
	input logic           storeValid,
	input mipsPkg::word   storeAddr,
	input mipsPkg::word   storeData
);
	import mipsPkg::*;

	// Expected events in program order
	regIdx expReg [$];
	word expRetireData [$];
	word expStoreAddr [$];
	word expStoreData [$];

	int errorCount = 0;
	int retireCount = 0;
	int storeCount = 0;

	task automatic expectRetire(input regIdx r, input word d);
		expReg.push_back(r);
		expRetireData.push_back(d);
	endtask

	task automatic expectStore(input word a, input word d);
		expStoreAddr.push_back(a);
		expStoreData.push_back(d);
	endtask

	function automatic int pendingEvents();
		return expReg.size() + expStoreAddr.size();
	endfunction

	// Compare one word, report in hex
	task automatic compareWord(input string name, input word got, input word exp);
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic checkRetire();
		retireCount++;
		if (expReg.size() == 0) begin
			errorCount++;
			$display("Retire of r%0d when the model expects no more register writes", retireReg);
		end else begin
			compareWord("retireReg", word'(retireReg), word'(expReg.pop_front()));
			compareWord("retireData", retireData, expRetireData.pop_front());
		end
	endtask

	task automatic checkStore();
		storeCount++;
		if (expStoreAddr.size() == 0) begin
			errorCount++;
			$display("Store to 0x%08h when the model expects no more stores", storeAddr);
		end else begin
			compareWord("storeAddr", storeAddr, expStoreAddr.pop_front());
			compareWord("storeData", storeData, expStoreData.pop_front());
		end
	endtask

	always @(posedge clk) begin
		if (arstN) begin
			// Load port follows run
			if (progReady !== !run) begin
				errorCount++;
				$display("Load port ready does not match the idle state of the core");
			end
			if (retireValid) begin
				checkRetire();
			end
			if (storeValid) begin
				checkStore();
			end
		end
	end

endmodule

/* tb/mipsProcessorTb.sv */
/* Runs several random programs that end in a self-branch; each needs PROG_LEN + 2 words
   Registers and data memory carry over from one program to the next like in the DUT */
`timescale 1ns/1ps

module mipsProcessorTb;
	import mipsPkg::*;

	localparam int PROG_LEN = 40;
	localparam int NUM_PROGS = 5;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 4 + 50);
	// Quiet cycles after the last expected event
	localparam int DRAIN_CYCLES = 10;

	logic clk = 1'b0;
	logic arstN, run, progValid, progReady;
	imemAddr progAddr;
	word progData;
	logic retireValid, storeValid;
	regIdx retireReg;
	word retireData, storeAddr, storeData;

	word prog [IMEM_DEPTH];
	word modelRegs [32];
	word modelMem [DMEM_DEPTH];
	logic [31:0] lcgState = 32'hdbe7_ec0b;
	int cycles = 0;

	always #10 clk = ~clk;

	mipsProcessor mipsProcessor_inst (.*);

	mipsChecker mipsChecker_inst (.*);

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, programs not finished within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Upper LCG bits since the low ones cycle quickly
	function automatic int randBelow(int n);
		logic [31:0] r;
		r = nextRandom();
		return int'(r[31:16]) % n;
	endfunction

	// Small register set so dependences are frequent
	function automatic regIdx randReg();
		return regIdx'(randBelow(8));
	endfunction

	function automatic funct pickFunct();
		case (randBelow(5))
			0: return fnAdd;
			1: return fnSub;
			2: return fnAnd;
			3: return fnOr;
			default: return fnNor;
		endcase
	endfunction

	function automatic word rType(funct f, regIdx rd, regIdx rs, regIdx rt);
		return {6'h00, rs, rt, rd, 5'h00, f};
	endfunction

	function automatic word iType(opcode op, regIdx rs, regIdx rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// or into r0 with sources from the address so it never retires
	function automatic word padWord(imemAddr a);
		return {6'h00, a[4:0], 4'h0, a[5], 5'h00, 5'h00, fnOr};
	endfunction

	task automatic buildProgram();
		int kind;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			kind = randBelow(16);
			if (kind < 6) begin
				prog[i] = rType(pickFunct(), randReg(), randReg(), randReg());
			end else if (kind < 8) begin
				prog[i] = iType(opAddi, randReg(), randReg(), 16'(randBelow(65536)));
			end else if (kind < 9) begin
				prog[i] = iType(opOri, randReg(), randReg(), 16'(randBelow(65536)));
			end else if (kind < 11) begin
				prog[i] = iType(opLw, randReg(), randReg(), 16'(randBelow(65536)));
			end else if (kind < 13) begin
				prog[i] = iType(opSw, randReg(), randReg(), 16'(randBelow(65536)));
			end else if (kind < 14) begin
				// Forward only and at most up to the self-branch
				prog[i] = iType(opBeq, randReg(), randReg(), 16'(randBelow(PROG_LEN - 1 - i)));
			end else begin
				prog[i] = iType(opBne, randReg(), randReg(), 16'(randBelow(PROG_LEN - 1 - i)));
			end
		end
		prog[PROG_LEN - 1] = iType(opBeq, 5'd0, 5'd0, 16'hffff);
		// The two slots fetched behind the self-branch
		prog[PROG_LEN] = padWord(imemAddr'(PROG_LEN));
		prog[PROG_LEN + 1] = padWord(imemAddr'(PROG_LEN + 1));
	endtask

	task automatic writeReg(regIdx r, word v);
		if (r != '0) begin
			modelRegs[r] = v;
			mipsChecker_inst.expectRetire(r, v);
		end
	endtask

	// Sequential ISA model without delay slots
	task automatic runModel();
		int pc;
		int steps;
		word ins, a, b, sext, addr;
		regIdx rs, rt, rd;
		pc = 0;
		steps = 0;
		while (pc != PROG_LEN - 1 && steps < 4 * PROG_LEN) begin
			ins = prog[pc];
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			sext = {{16{ins[15]}}, ins[15:0]};
			a = modelRegs[rs];
			b = modelRegs[rt];
			addr = a + sext;
			pc = pc + 1;
			steps++;
			case (ins[31:26])
				opRType: begin
					case (ins[5:0])
						fnAdd: writeReg(rd, a + b);
						fnSub: writeReg(rd, a - b);
						fnAnd: writeReg(rd, a & b);
						fnOr: writeReg(rd, a | b);
						default: writeReg(rd, ~(a | b));
					endcase
				end
				opAddi: writeReg(rt, addr);
				opOri: writeReg(rt, a | {16'h0000, ins[15:0]});
				// Word index from address bits 7:2
				opLw: writeReg(rt, modelMem[addr[7:2]]);
				opSw: begin
					modelMem[addr[7:2]] = b;
					mipsChecker_inst.expectStore(addr, b);
				end
				default: begin
					if ((ins[31:26] == opBeq) == (a == b)) begin
						pc = (pc + int'(signed'(ins[15:0]))) % IMEM_DEPTH;
					end
				end
			endcase
		end
	endtask

	// One word per accepted handshake
	task automatic loadProgram();
		int i;
		i = 0;
		while (i < PROG_LEN + 2) begin
			@(negedge clk);
			progValid = 1'b1;
			progAddr = imemAddr'(i);
			progData = prog[i];
			@(posedge clk);
			if (progReady) begin
				i++;
			end
		end
		@(negedge clk);
		progValid = 1'b0;
	endtask

	initial begin
		arstN = 1'b0;
		run = 1'b0;
		progValid = 1'b0;
		progAddr = '0;
		progData = '0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			modelMem[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		for (int p = 0; p < NUM_PROGS; p++) begin
			buildProgram();
			runModel();
			loadProgram();
			run = 1'b1;
			// Garbage offered over the self-branch while running must be refused
			progValid = 1'b1;
			progAddr = imemAddr'(PROG_LEN - 1);
			progData = nextRandom();
			while (mipsChecker_inst.pendingEvents() != 0) begin
				@(posedge clk);
			end
			// Anything after the self-branch shows up as an extra event
			repeat (DRAIN_CYCLES) @(posedge clk);
			@(negedge clk);
			run = 1'b0;
			progValid = 1'b0;
			repeat (2) @(negedge clk);
		end
		$display("Summary: %0d retires, %0d stores, %0d errors",
			mipsChecker_inst.retireCount, mipsChecker_inst.storeCount,
			mipsChecker_inst.errorCount);
		if (mipsChecker_inst.errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* tb/mipsProcessor_props.sv */
/* Bound into mipsProcessor and sampled on the rising clock edge
   Idle checks allow one cycle after run drops for the pipeline to empty */
`timescale 1ns/1ps

module mipsProcessor_props (
	input logic           clk,
	input logic           arstN,
	input logic           run,
	input logic           progReady,
	input logic           retireValid,
	input mipsPkg::regIdx retireReg,
	input logic           storeValid
);

	// Writes to r0 stay hidden
	retireNotZero: assert property (@(posedge clk) disable iff (!arstN)
		retireValid |-> retireReg != '0)
		else $error("retire reported register 0");

	// Load port open exactly while idle
	loadPortIdle: assert property (@(posedge clk) disable iff (!arstN)
		progReady == !run)
		else $error("load port state does not follow run");

	// Nothing leaves the core while idle
	quietWhileIdle: assert property (@(posedge clk) disable iff (!arstN)
		(!run && !$past(run)) |-> (!retireValid && !storeValid))
		else $error("retire or store seen while the core is idle");

	// Out of reset with the load port open
	quietAfterReset: assert property (@(posedge clk)
		$rose(arstN) |-> (progReady && !retireValid && !storeValid))
		else $error("outputs not quiet after reset");

endmodule

bind mipsProcessor mipsProcessor_props mipsProcessor_props_inst (.*);
